/* logic/xbar_config.svh */
`ifndef XBAR_CONFIG_SVH
`define XBAR_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

// requester tag carried with every request and response
`define XBAR_ID_WIDTH   8

// byte address as seen by the masters
`define XBAR_ADDR_WIDTH 32

// one data word
`define XBAR_DATA_WIDTH 24

//////////////////////////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////////////////////////

// each region ends where the next one starts
`define XBAR_RAYS_BASE  32'h0000_0000
`define XBAR_BRAM_BASE  32'h0000_0011

// dram takes everything from here up
`define XBAR_DRAM_BASE  32'h0000_0080

`endif

/* logic/xbarPkg.sv */
`include "xbar_config.svh"

package xbarPkg;

    //////////////////////////////////////////////////////////////////
    // bus fields
    //////////////////////////////////////////////////////////////////

    // tag of the requesting master
    typedef logic [`XBAR_ID_WIDTH-1:0] memId_t;

    // byte address
    typedef logic [`XBAR_ADDR_WIDTH-1:0] memAddr_t;

    // data word
    typedef logic [`XBAR_DATA_WIDTH-1:0] memData_t;

    //////////////////////////////////////////////////////////////////
    // priority state
    //////////////////////////////////////////////////////////////////

    // master that waited longest on a slave port
    typedef enum logic {
        ownerRay,
        ownerPs
    } reqOwner_t;

    // slave whose response went out last
    typedef enum logic [1:0] {
        srcRayS,
        srcBram,
        srcDram
    } respSrc_t;

endpackage

/* logic/reqRouter.sv */
`timescale 1ns/1ps

`include "xbar_config.svh"

module reqRouter import xbarPkg::*; (
    input  memAddr_t   rayAddr,
    input  logic       rayValid,
    input  memAddr_t   psAddr,
    input  logic       psValid,
    // one bit per slave in order ray slave, bram, dram
    input  logic [2:0] arbRayTaken,
    input  logic [2:0] arbPsTaken,
    output logic [2:0] rayHit,
    output logic [2:0] psHit,
    output logic       rayTaken,
    output logic       psTaken
);

    //////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////

    function automatic logic [2:0] decodeRegion(memAddr_t addr);
        logic [2:0] region;
        region = 3'b000;
        if (addr >= `XBAR_DRAM_BASE) begin
            region[2] = 1'b1;
        end else if (addr >= `XBAR_BRAM_BASE) begin
            region[1] = 1'b1;
        end else begin
            // everything below bram belongs to the ray slave
            region[0] = 1'b1;
        end
        return region;
    endfunction

    // a hit only counts while the master actually drives a request
    assign rayHit = rayValid ? decodeRegion(rayAddr) : 3'b000;
    assign psHit  = psValid ? decodeRegion(psAddr) : 3'b000;

    //////////////////////////////////////////////////////////////////
    // taken fold
    //////////////////////////////////////////////////////////////////

    // each master hits one slave at most, so OR picks the live one
    assign rayTaken = |arbRayTaken;
    assign psTaken  = |arbPsTaken;

endmodule

/* logic/reqArbiter.sv */
`timescale 1ns/1ps

`include "xbar_config.svh"

module reqArbiter import xbarPkg::*; #(
    // subtracted from the winner's address before it reaches the slave
    parameter memAddr_t regionBase = `XBAR_RAYS_BASE
) (
    input  logic     clk,
    input  logic     rst,

    // requests already filtered down to this slave's region
    input  logic     rayHit,
    input  logic     psHit,

    input  memId_t   rayId,
    input  memAddr_t rayAddr,
    input  memData_t rayData,
    input  logic     rayWrite,

    input  memId_t   psId,
    input  memAddr_t psAddr,
    input  memData_t psData,
    input  logic     psWrite,

    // slave side
    input  logic     slvTaken,
    output memId_t   slvId,
    output memAddr_t slvAddr,
    output memData_t slvData,
    output logic     slvWrite,
    output logic     slvValid,

    // back to the router
    output logic     rayTaken,
    output logic     psTaken
);

    //////////////////////////////////////////////////////////////////
    // grant
    //////////////////////////////////////////////////////////////////

    // least recently served master wins a tie
    reqOwner_t lrsOwner;
    logic      pickPs;

    always_comb begin
        if (rayHit && psHit) begin
            pickPs = (lrsOwner == ownerPs);
        end else begin
            pickPs = psHit;
        end
    end

    //////////////////////////////////////////////////////////////////
    // request mux
    //////////////////////////////////////////////////////////////////

    assign slvValid = rayHit | psHit;

    always_comb begin
        if (pickPs) begin
            slvId    = psId;
            slvAddr  = psAddr - regionBase;
            slvData  = psData;
            slvWrite = psWrite;
        end else begin
            slvId    = rayId;
            slvAddr  = rayAddr - regionBase;
            slvData  = rayData;
            slvWrite = rayWrite;
        end
    end

    // the loser never sees taken
    assign rayTaken = rayHit & ~pickPs & slvTaken;
    assign psTaken  = pickPs & slvTaken;

    //////////////////////////////////////////////////////////////////
    // priority update
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            lrsOwner <= ownerPs;
        end else if (rayTaken) begin
            lrsOwner <= ownerPs;
        end else if (psTaken) begin
            lrsOwner <= ownerRay;
        end
    end

    // a served contended master yields the next contended grant
    assert property (@(posedge clk) disable iff (rst)
        (rayHit && psHit && slvTaken) |=> (!(rayHit && psHit) || (pickPs != $past(pickPs))))
    else $error("contended grant did not rotate after a transfer");

    // a stalled contended grant must not hop to the other master
    assert property (@(posedge clk) disable iff (rst)
        (rayHit && psHit && !slvTaken) |=> (!(rayHit && psHit) || $stable(pickPs)))
    else $error("grant moved while the slave held back");

endmodule

/* logic/respMerger.sv */
`timescale 1ns/1ps

`include "xbar_config.svh"

module respMerger import xbarPkg::*; (
    input  logic     clk,
    input  logic     rst,

    // slave responses
    input  memId_t   raySId,
    input  memData_t raySData,
    input  logic     raySValid,

    input  memId_t   bramId,
    input  memData_t bramData,
    input  logic     bramValid,

    input  memId_t   dramId,
    input  memData_t dramData,
    input  logic     dramValid,

    // either master can accept the broadcast
    input  logic     rayRespTaken,
    input  logic     psRespTaken,

    // same response goes to both masters
    output memId_t   respId,
    output memData_t respData,
    output logic     respValid,

    output logic     raySTaken,
    output logic     bramTaken,
    output logic     dramTaken
);

    respSrc_t   lastSrc;
    respSrc_t   pick;
    respSrc_t   order [3];
    logic       anyValid;
    logic       accept;
    logic [2:0] srcValid;
    memId_t     srcId [3];
    memData_t   srcData [3];

    // index by source enum
    assign srcValid = {dramValid, bramValid, raySValid};

    assign srcId[srcRayS]   = raySId;
    assign srcId[srcBram]   = bramId;
    assign srcId[srcDram]   = dramId;
    assign srcData[srcRayS] = raySData;
    assign srcData[srcBram] = bramData;
    assign srcData[srcDram] = dramData;

    //////////////////////////////////////////////////////////////////
    // rotating search
    //////////////////////////////////////////////////////////////////

    // start just after the last served source
    always_comb begin
        case (lastSrc)
            srcRayS: order = '{srcBram, srcDram, srcRayS};
            srcBram: order = '{srcDram, srcRayS, srcBram};
            default: order = '{srcRayS, srcBram, srcDram};
        endcase
    end

    // walk backwards so the earliest valid entry wins
    always_comb begin
        pick     = lastSrc;
        anyValid = 1'b0;
        for (int k = 2; k >= 0; k--) begin
            if (srcValid[order[k]]) begin
                pick     = order[k];
                anyValid = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // broadcast and taken
    //////////////////////////////////////////////////////////////////

    assign respValid = anyValid;
    assign respId    = srcId[pick];
    assign respData  = srcData[pick];

    assign accept = rayRespTaken | psRespTaken;

    assign raySTaken = anyValid && (pick == srcRayS) && accept;
    assign bramTaken = anyValid && (pick == srcBram) && accept;
    assign dramTaken = anyValid && (pick == srcDram) && accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            lastSrc <= srcRayS;
        end else if (anyValid && accept) begin
            lastSrc <= pick;
        end
    end

    // a response nobody took stays selected while the valids hold
    assert property (@(posedge clk) disable iff (rst)
        (anyValid && !accept) |=> (!$stable(srcValid) || $stable(pick)))
    else $error("response selection moved without a transfer");

endmodule

/* logic/memCrossbar.sv */
`timescale 1ns/1ps

`include "xbar_config.svh"

module memCrossbar import xbarPkg::*; (
    input  logic     clk,
    input  logic     rst,

    // ray unit master
    input  memId_t   rayId,
    input  memAddr_t rayAddr,
    input  memData_t rayData,
    input  logic     rayWrite,
    input  logic     rayValid,
    output logic     rayTaken,
    output memId_t   rayRespId,
    output memData_t rayRespData,
    output logic     rayRespValid,
    input  logic     rayRespTaken,

    // processing system master
    input  memId_t   psId,
    input  memAddr_t psAddr,
    input  memData_t psData,
    input  logic     psWrite,
    input  logic     psValid,
    output logic     psTaken,
    output memId_t   psRespId,
    output memData_t psRespData,
    output logic     psRespValid,
    input  logic     psRespTaken,

    // ray register slave
    output memId_t   raySlvId,
    output memAddr_t raySlvAddr,
    output memData_t raySlvData,
    output logic     raySlvWrite,
    output logic     raySlvValid,
    input  logic     raySlvTaken,
    input  memId_t   raySlvRespId,
    input  memData_t raySlvRespData,
    input  logic     raySlvRespValid,
    output logic     raySlvRespTaken,

    // block ram
    output memId_t   bramId,
    output memAddr_t bramAddr,
    output memData_t bramData,
    output logic     bramWrite,
    output logic     bramValid,
    input  logic     bramTaken,
    input  memId_t   bramRespId,
    input  memData_t bramRespData,
    input  logic     bramRespValid,
    output logic     bramRespTaken,

    // dram
    output memId_t   dramId,
    output memAddr_t dramAddr,
    output memData_t dramData,
    output logic     dramWrite,
    output logic     dramValid,
    input  logic     dramTaken,
    input  memId_t   dramRespId,
    input  memData_t dramRespData,
    input  logic     dramRespValid,
    output logic     dramRespTaken
);

    // [0] ray slave, [1] bram, [2] dram
    logic [2:0] rayHit;
    logic [2:0] psHit;
    logic [2:0] arbRayTaken;
    logic [2:0] arbPsTaken;

    //////////////////////////////////////////////////////////////////
    // request path
    //////////////////////////////////////////////////////////////////

    reqRouter u_router (
        .rayAddr     (rayAddr),
        .rayValid    (rayValid),
        .psAddr      (psAddr),
        .psValid     (psValid),
        .arbRayTaken (arbRayTaken),
        .arbPsTaken  (arbPsTaken),
        .rayHit      (rayHit),
        .psHit       (psHit),
        .rayTaken    (rayTaken),
        .psTaken     (psTaken)
    );

    reqArbiter #(.regionBase(`XBAR_RAYS_BASE)) u_arbRayS (
        .clk      (clk),
        .rst      (rst),
        .rayHit   (rayHit[0]),
        .psHit    (psHit[0]),
        .rayId    (rayId),
        .rayAddr  (rayAddr),
        .rayData  (rayData),
        .rayWrite (rayWrite),
        .psId     (psId),
        .psAddr   (psAddr),
        .psData   (psData),
        .psWrite  (psWrite),
        .slvTaken (raySlvTaken),
        .slvId    (raySlvId),
        .slvAddr  (raySlvAddr),
        .slvData  (raySlvData),
        .slvWrite (raySlvWrite),
        .slvValid (raySlvValid),
        .rayTaken (arbRayTaken[0]),
        .psTaken  (arbPsTaken[0])
    );

    reqArbiter #(.regionBase(`XBAR_BRAM_BASE)) u_arbBram (
        .clk      (clk),
        .rst      (rst),
        .rayHit   (rayHit[1]),
        .psHit    (psHit[1]),
        .rayId    (rayId),
        .rayAddr  (rayAddr),
        .rayData  (rayData),
        .rayWrite (rayWrite),
        .psId     (psId),
        .psAddr   (psAddr),
        .psData   (psData),
        .psWrite  (psWrite),
        .slvTaken (bramTaken),
        .slvId    (bramId),
        .slvAddr  (bramAddr),
        .slvData  (bramData),
        .slvWrite (bramWrite),
        .slvValid (bramValid),
        .rayTaken (arbRayTaken[1]),
        .psTaken  (arbPsTaken[1])
    );

    // dram sees the full master address
    reqArbiter #(.regionBase('0)) u_arbDram (
        .clk      (clk),
        .rst      (rst),
        .rayHit   (rayHit[2]),
        .psHit    (psHit[2]),
        .rayId    (rayId),
        .rayAddr  (rayAddr),
        .rayData  (rayData),
        .rayWrite (rayWrite),
        .psId     (psId),
        .psAddr   (psAddr),
        .psData   (psData),
        .psWrite  (psWrite),
        .slvTaken (dramTaken),
        .slvId    (dramId),
        .slvAddr  (dramAddr),
        .slvData  (dramData),
        .slvWrite (dramWrite),
        .slvValid (dramValid),
        .rayTaken (arbRayTaken[2]),
        .psTaken  (arbPsTaken[2])
    );

    //////////////////////////////////////////////////////////////////
    // response path
    //////////////////////////////////////////////////////////////////

    respMerger u_merger (
        .clk          (clk),
        .rst          (rst),
        .raySId       (raySlvRespId),
        .raySData     (raySlvRespData),
        .raySValid    (raySlvRespValid),
        .bramId       (bramRespId),
        .bramData     (bramRespData),
        .bramValid    (bramRespValid),
        .dramId       (dramRespId),
        .dramData     (dramRespData),
        .dramValid    (dramRespValid),
        .rayRespTaken (rayRespTaken),
        .psRespTaken  (psRespTaken),
        .respId       (rayRespId),
        .respData     (rayRespData),
        .respValid    (rayRespValid),
        .raySTaken    (raySlvRespTaken),
        .bramTaken    (bramRespTaken),
        .dramTaken    (dramRespTaken)
    );

    // ps gets the same broadcast
    assign psRespId    = rayRespId;
    assign psRespData  = rayRespData;
    assign psRespValid = rayRespValid;

endmodule

/* test/tbMemCrossbar.sv */
`timescale 1ns/1ps

`include "xbar_config.svh"

module tbMemCrossbar import xbarPkg::*; ();

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 9;
    // routing, contention, parallel, back-pressure, merge, idle, plus four resets
    localparam int testCycles  = 6 + 5 + 2 + 7 + 11 + 2 + 4 * resetCycles;
    localparam int watchdogNs  = (testCycles + 50) * clkPeriod;

    // region starts indexed like the slave arrays
    localparam memAddr_t regionBases [3] = '{`XBAR_RAYS_BASE, `XBAR_BRAM_BASE, `XBAR_DRAM_BASE};

    logic     clk;
    logic     rst;
    memId_t   rayId, psId;
    memAddr_t rayAddr, psAddr;
    memData_t rayData, psData;
    logic     rayWrite, psWrite, rayValid, psValid, rayTaken, psTaken;
    memId_t   rayRespId, psRespId;
    memData_t rayRespData, psRespData;
    logic     rayRespValid, psRespValid, rayRespTaken, psRespTaken;

    // slave side indexed [0] ray slave, [1] bram, [2] dram
    memId_t   slvId [3];
    memAddr_t slvAddr [3];
    memData_t slvData [3];
    logic     slvWrite [3];
    logic     slvValid [3];
    logic     slvTaken [3];
    memId_t   slvRespId [3];
    memData_t slvRespData [3];
    logic     slvRespValid [3];
    logic     slvRespTaken [3];

    int checks;
    int errors;

    memCrossbar u_dut (
        .clk (clk), .rst (rst),
        .rayId (rayId), .rayAddr (rayAddr), .rayData (rayData), .rayWrite (rayWrite),
        .rayValid (rayValid), .rayTaken (rayTaken), .rayRespId (rayRespId),
        .rayRespData (rayRespData), .rayRespValid (rayRespValid), .rayRespTaken (rayRespTaken),
        .psId (psId), .psAddr (psAddr), .psData (psData), .psWrite (psWrite),
        .psValid (psValid), .psTaken (psTaken), .psRespId (psRespId),
        .psRespData (psRespData), .psRespValid (psRespValid), .psRespTaken (psRespTaken),
        .raySlvId (slvId[0]), .raySlvAddr (slvAddr[0]), .raySlvData (slvData[0]),
        .raySlvWrite (slvWrite[0]), .raySlvValid (slvValid[0]), .raySlvTaken (slvTaken[0]),
        .raySlvRespId (slvRespId[0]), .raySlvRespData (slvRespData[0]),
        .raySlvRespValid (slvRespValid[0]), .raySlvRespTaken (slvRespTaken[0]),
        .bramId (slvId[1]), .bramAddr (slvAddr[1]), .bramData (slvData[1]),
        .bramWrite (slvWrite[1]), .bramValid (slvValid[1]), .bramTaken (slvTaken[1]),
        .bramRespId (slvRespId[1]), .bramRespData (slvRespData[1]),
        .bramRespValid (slvRespValid[1]), .bramRespTaken (slvRespTaken[1]),
        .dramId (slvId[2]), .dramAddr (slvAddr[2]), .dramData (slvData[2]),
        .dramWrite (slvWrite[2]), .dramValid (slvValid[2]), .dramTaken (slvTaken[2]),
        .dramRespId (slvRespId[2]), .dramRespData (slvRespData[2]),
        .dramRespValid (slvRespValid[2]), .dramRespTaken (slvRespTaken[2])
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("timeout: the run did not finish within %0d ns", watchdogNs);
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkId(memId_t got, memId_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkAddr(memAddr_t got, memAddr_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkData(memData_t got, memData_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic clearInputs();
        rayId = '0;
        rayAddr = '0;
        rayData = '0;
        rayWrite = 1'b0;
        rayValid = 1'b0;
        psId = '0;
        psAddr = '0;
        psData = '0;
        psWrite = 1'b0;
        psValid = 1'b0;
        rayRespTaken = 1'b0;
        psRespTaken = 1'b0;
        for (int s = 0; s < 3; s++) begin
            slvTaken[s] = 1'b0;
            slvRespId[s] = '0;
            slvRespData[s] = '0;
            slvRespValid[s] = 1'b0;
        end
    endtask

    task automatic resetDut();
        @(negedge clk);
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    // random address inside region r
    function automatic memAddr_t pickAddr(int r);
        if (r == 0) begin
            return `XBAR_RAYS_BASE + ($urandom % (`XBAR_BRAM_BASE - `XBAR_RAYS_BASE));
        end else if (r == 1) begin
            return `XBAR_BRAM_BASE + ($urandom % (`XBAR_DRAM_BASE - `XBAR_BRAM_BASE));
        end
        return `XBAR_DRAM_BASE + ($urandom % 32'h1000_0000);
    endfunction

    task automatic driveRay(memAddr_t addr);
        rayId = memId_t'($urandom);
        rayData = memData_t'($urandom);
        rayWrite = 1'($urandom);
        rayAddr = addr;
        rayValid = 1'b1;
    endtask

    task automatic drivePs(memAddr_t addr);
        psId = memId_t'($urandom);
        psData = memData_t'($urandom);
        psWrite = 1'($urandom);
        psAddr = addr;
        psValid = 1'b1;
    endtask

    task automatic presentResp(respSrc_t s);
        slvRespId[s] = memId_t'($urandom);
        slvRespData[s] = memData_t'($urandom);
        slvRespValid[s] = 1'b1;
    endtask

    // rotation order ray slave, bram, dram, then around again
    function automatic respSrc_t nextSrc(respSrc_t s);
        case (s)
            srcRayS: return srcBram;
            srcBram: return srcDram;
            default: return srcRayS;
        endcase
    endfunction

    task automatic expectResponse(respSrc_t src, logic taken);
        checkBit(rayRespValid, 1'b1, "ray respValid");
        checkBit(psRespValid, 1'b1, "ps respValid");
        checkId(rayRespId, slvRespId[src], "ray respId");
        checkId(psRespId, slvRespId[src], "ps respId");
        checkData(rayRespData, slvRespData[src], "ray respData");
        checkData(psRespData, slvRespData[src], "ps respData");
        for (int s = 0; s < 3; s++) begin
            checkBit(slvRespTaken[s], taken && (s == int'(src)), "slave respTaken");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic routeToEachRegion();
        memAddr_t addr;
        for (int m = 0; m < 2; m++) begin
            for (int r = 0; r < 3; r++) begin
                @(negedge clk);
                clearInputs();
                addr = pickAddr(r);
                if (m == 0) driveRay(addr);
                else drivePs(addr);
                for (int s = 0; s < 3; s++) slvTaken[s] = 1'b1;
                #1;
                for (int s = 0; s < 3; s++) checkBit(slvValid[s], s == r, "slave valid");
                // dram keeps the full address
                checkAddr(slvAddr[r], (r == 2) ? addr : addr - regionBases[r], "slave addr");
                checkId(slvId[r], (m == 0) ? rayId : psId, "slave id");
                checkData(slvData[r], (m == 0) ? rayData : psData, "slave data");
                checkBit(slvWrite[r], (m == 0) ? rayWrite : psWrite, "slave write");
                checkBit(rayTaken, m == 0, "ray reqTaken");
                checkBit(psTaken, m == 1, "ps reqTaken");
            end
        end
        @(negedge clk);
        clearInputs();
    endtask

    task automatic alternateOnBram();
        reqOwner_t expOwner;
        resetDut();
        driveRay(pickAddr(1));
        drivePs(pickAddr(1));
        slvTaken[1] = 1'b1;
        expOwner = ownerPs;
        for (int n = 0; n < 4; n++) begin
            #1;
            checkId(slvId[1], (expOwner == ownerPs) ? psId : rayId, "contended bram id");
            checkAddr(slvAddr[1], ((expOwner == ownerPs) ? psAddr : rayAddr) - `XBAR_BRAM_BASE,
                "contended bram addr");
            checkBit(rayTaken, expOwner == ownerRay, "contended ray reqTaken");
            checkBit(psTaken, expOwner == ownerPs, "contended ps reqTaken");
            @(negedge clk);
            // served master moves on to a fresh request
            if (expOwner == ownerPs) drivePs(pickAddr(1));
            else driveRay(pickAddr(1));
            expOwner = (expOwner == ownerPs) ? ownerRay : ownerPs;
        end
        clearInputs();
    endtask

    task automatic serveTwoSlavesAtOnce();
        @(negedge clk);
        driveRay(pickAddr(2));
        drivePs(pickAddr(0));
        for (int s = 0; s < 3; s++) slvTaken[s] = 1'b1;
        #1;
        checkBit(slvValid[2], 1'b1, "dram valid");
        checkBit(slvValid[0], 1'b1, "ray slave valid");
        checkBit(slvValid[1], 1'b0, "bram valid");
        checkId(slvId[2], rayId, "dram id");
        checkAddr(slvAddr[2], rayAddr, "dram addr");
        checkId(slvId[0], psId, "ray slave id");
        checkAddr(slvAddr[0], psAddr - `XBAR_RAYS_BASE, "ray slave addr");
        checkBit(rayTaken, 1'b1, "parallel ray reqTaken");
        checkBit(psTaken, 1'b1, "parallel ps reqTaken");
        @(negedge clk);
        clearInputs();
    endtask

    task automatic holdDramStalled();
        resetDut();
        driveRay(pickAddr(2));
        drivePs(pickAddr(2));
        for (int n = 0; n < 4; n++) begin
            #1;
            checkBit(slvValid[2], 1'b1, "stalled dram valid");
            checkId(slvId[2], psId, "stalled dram id");
            checkAddr(slvAddr[2], psAddr, "stalled dram addr");
            checkBit(rayTaken, 1'b0, "stalled ray reqTaken");
            checkBit(psTaken, 1'b0, "stalled ps reqTaken");
            @(negedge clk);
        end
        slvTaken[2] = 1'b1;
        #1;
        checkId(slvId[2], psId, "released dram id");
        checkBit(psTaken, 1'b1, "released ps reqTaken");
        checkBit(rayTaken, 1'b0, "released ray reqTaken");
        @(negedge clk);
        drivePs(pickAddr(2));
        #1;
        checkId(slvId[2], rayId, "next dram id");
        checkBit(rayTaken, 1'b1, "next ray reqTaken");
        checkBit(psTaken, 1'b0, "next ps reqTaken");
        @(negedge clk);
        clearInputs();
    endtask

    task automatic rotateResponses();
        respSrc_t expSrc;
        resetDut();
        presentResp(srcRayS);
        presentResp(srcBram);
        presentResp(srcDram);
        // nothing taken yet, so the pick stays put
        for (int n = 0; n < 3; n++) begin
            #1;
            expectResponse(srcBram, 1'b0);
            @(negedge clk);
        end
        expSrc = srcBram;
        for (int n = 0; n < 6; n++) begin
            rayRespTaken = n[0];
            psRespTaken = ~n[0];
            #1;
            expectResponse(expSrc, 1'b1);
            @(negedge clk);
            presentResp(expSrc);
            expSrc = nextSrc(expSrc);
        end
        clearInputs();
    endtask

    task automatic stayIdle();
        @(negedge clk);
        clearInputs();
        for (int s = 0; s < 3; s++) slvTaken[s] = 1'b1;
        rayRespTaken = 1'b1;
        psRespTaken = 1'b1;
        #1;
        for (int s = 0; s < 3; s++) begin
            checkBit(slvValid[s], 1'b0, "idle slave valid");
            checkBit(slvRespTaken[s], 1'b0, "idle slave respTaken");
        end
        checkBit(rayTaken, 1'b0, "idle ray reqTaken");
        checkBit(psTaken, 1'b0, "idle ps reqTaken");
        checkBit(rayRespValid, 1'b0, "idle ray respValid");
        checkBit(psRespValid, 1'b0, "idle ps respValid");
        @(negedge clk);
        clearInputs();
    endtask

    initial begin
        checks = 0;
        errors = 0;
        rst = 1'b1;
        clearInputs();
        void'($urandom(91807));
        resetDut();
        routeToEachRegion();
        alternateOnBram();
        serveTwoSlavesAtOnce();
        holdDramStalled();
        rotateResponses();
        stayIdle();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+logic
logic/xbarPkg.sv
logic/reqRouter.sv
logic/reqArbiter.sv
logic/respMerger.sv
logic/memCrossbar.sv
test/tbMemCrossbar.sv

/* run.sh */
#!/bin/sh
# build the crossbar testbench with verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tbMemCrossbar -o simXbar \
    && ./obj_dir/simXbar | tee sim.log \
    || echo "build or simulation did not complete"
grep -qx "Test OK" sim.log && exit 0 || exit 1
